// File: verilog/cart_pkg.sv
//==============================
// Cartridge loader package
// Shared widths, header offsets, fill patterns and sequencer states
//==============================

`default_nettype none

package cart_pkg;

	// Widths with a meaning
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_word_t;
	typedef logic [23:0] mask_t;
	typedef logic [31:0] lba_t;
	typedef logic [16:0] fill_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [2:0]  hdr_mode_t;

	// Header mode from the menu
	localparam hdr_mode_t HDR_AUTO    = 3'd0;
	localparam hdr_mode_t HDR_NONE    = 3'd1;
	localparam hdr_mode_t HDR_LOROM   = 3'd2;
	localparam hdr_mode_t HDR_HIROM   = 3'd3;
	localparam hdr_mode_t HDR_EXHIROM = 3'd4;

	// Download index of a cartridge image
	localparam logic [5:0] CART_INDEX = 6'd0;

	// ROM header locations, ROM size byte at base, RAM size byte at base+2
	localparam dl_addr_t COPIER_HEADER = 25'd512;
	localparam dl_addr_t LOROM_HDR     = 25'h0007FD6;
	localparam dl_addr_t HIROM_HDR     = 25'h000FFD6;
	localparam dl_addr_t EXHIROM_HDR   = 25'h040FFD6;

	localparam size_code_t DEFAULT_ROM_SIZE = 4'hC;
	localparam mask_t      MASK_UNIT        = 24'd1024;

	// Power-on patterns, upper byte when the address bits differ
	localparam logic [15:0] FILL_PAT_A = 16'h6699;
	localparam logic [15:0] FILL_PAT_B = 16'hFF00;
	localparam byte_t       FILL_PAT_C = 8'h55;
	localparam byte_t       FILL_PAT_D = 8'hFF;

	// 512-byte sectors on the SD link
	localparam int SECTOR_SHIFT = 9;

	// Backup RAM transfer sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQUEST,
		SEQ_TRANSFER
	} seq_state_e;

endpackage

`default_nettype wire

// File: verilog/cart_header_parse.sv
//==============================
// Cartridge header parser
// Picks ROM type, ROM/RAM masks and region out of the download
//==============================

`timescale 1ns/10ps
`default_nettype none

module cart_header_parse import cart_pkg::*; (
	input  wire        clk_sys,
	input  wire        RESET,
	input  wire        cart_download,
	input  dl_addr_t   ioctl_addr,
	input  dl_word_t   ioctl_dout,
	input  wire        ioctl_wr,
	input  hdr_mode_t  header_mode,
	input  wire  [1:0] video_region,
	output byte_t      rom_type,
	output mask_t      rom_mask,
	output mask_t      ram_mask,
	output logic       pal
);

	size_code_t rom_size;
	size_code_t ram_size;
	logic       rom_region;

	// Header base in download addresses for the forced modes
	logic     hdr_map;
	dl_addr_t hdr_base;

	always_comb begin
		hdr_map  = 1'b0;
		hdr_base = '0;
		case (header_mode)
			HDR_LOROM: begin
				hdr_map  = 1'b1;
				hdr_base = LOROM_HDR + COPIER_HEADER;
			end
			HDR_HIROM: begin
				hdr_map  = 1'b1;
				hdr_base = HIROM_HDR + COPIER_HEADER;
			end
			HDR_EXHIROM: begin
				hdr_map  = 1'b1;
				hdr_base = EXHIROM_HDR + COPIER_HEADER;
			end
			default: begin
				hdr_map  = 1'b0;
				hdr_base = '0;
			end
		endcase
	end

	// ==============================
	// Header capture
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= '0;
			rom_type   <= '0;
			rom_region <= 1'b0;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (ioctl_addr == '0) begin
					rom_size <= DEFAULT_ROM_SIZE;
					ram_size <= '0;
					// Auto mode takes sizes from the first byte if present
					if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00)
						{ram_size, rom_size} <= ioctl_dout[7:0];
					case (header_mode)
						HDR_NONE, HDR_LOROM: rom_type <= 8'd0;
						HDR_HIROM:           rom_type <= 8'd1;
						HDR_EXHIROM:         rom_type <= 8'd2;
						default:             rom_type <= ioctl_dout[15:8];
					endcase
				end
				if (ioctl_addr == dl_addr_t'(2))
					rom_region <= ioctl_dout[8];
				// Mapped header overrides the sizes
				if (hdr_map) begin
					if (ioctl_addr == hdr_base)
						rom_size <= ioctl_dout[11:8];
					if (ioctl_addr == hdr_base + dl_addr_t'(2))
						ram_size <= ioctl_dout[3:0];
				end
			end
		end else begin
			pal <= (video_region == 2'b00) ? rom_region : video_region[1];
		end
	end

	// Masks follow the registered size codes
	assign rom_mask = (MASK_UNIT << rom_size) - mask_t'(1);
	assign ram_mask = (ram_size != '0) ? (MASK_UNIT << ram_size) - mask_t'(1) : '0;

endmodule

`default_nettype wire

// File: verilog/wram_clear.sv
//==============================
// Work RAM clearer
// Sweeps work RAM with the power-on pattern at download start
//==============================

`timescale 1ns/10ps
`default_nettype none

module wram_clear import cart_pkg::*; (
	input  wire        clk_sys,
	input  wire        RESET,
	input  wire        cart_download,
	input  wire  [1:0] wram_init,
	output fill_addr_t fill_addr,
	output byte_t      fill_data,
	output logic       fill_wr
);

	logic dl_q;
	logic clearing;

	// One full pass over the address space per download start
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			clearing  <= 1'b0;
			fill_addr <= '0;
		end else begin
			dl_q <= cart_download;
			if (cart_download && !dl_q)
				clearing <= 1'b1;
			else if (&fill_addr)
				clearing <= 1'b0;

			if (clearing)
				fill_addr <= fill_addr + fill_addr_t'(1);
			else
				fill_addr <= '0;
		end
	end

	assign fill_wr = clearing;

	// Pattern select
	always_comb begin
		case (wram_init)
			2'd0: fill_data = (fill_addr[8] ^ fill_addr[2]) ? FILL_PAT_A[15:8] : FILL_PAT_A[7:0];
			2'd1: fill_data = (fill_addr[9] ^ fill_addr[0]) ? FILL_PAT_B[15:8] : FILL_PAT_B[7:0];
			2'd2: fill_data = FILL_PAT_C;
			default: fill_data = FILL_PAT_D;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/backup_sequencer.sv
//==============================
// Backup RAM sequencer
// Tracks save RAM writes and moves the save file over the SD link
//==============================

`timescale 1ns/10ps
`default_nettype none

module backup_sequencer import cart_pkg::*; (
	input  wire   clk_sys,
	input  wire   RESET,
	input  wire   cart_download,
	input  mask_t ram_mask,
	input  wire   img_mounted,
	input  wire   img_readonly,
	input  lba_t  img_size,
	input  wire   bk_load_req,
	input  wire   bk_save_req,
	input  wire   autosave_en,
	input  wire   osd_open,
	input  wire   bsram_wr,
	input  wire   sd_ack,
	output lba_t  sd_lba,
	output logic  sd_rd,
	output logic  sd_wr,
	output logic  bk_loading,
	output logic  bk_pending
);

	seq_state_e state;
	logic       bk_ena;

	// Registered triggers, edges taken one stage later
	logic dl_q, dl_qq;
	logic load_q, load_qq;
	logic save_q, save_qq;
	logic auto_q, auto_qq;
	logic ack_q;

	logic dl_rise, dl_fall;
	logic load_rise, save_rise, auto_rise;
	logic ack_rise, ack_fall;
	lba_t last_sector;

	assign dl_rise   = dl_q & ~dl_qq;
	assign dl_fall   = dl_qq & ~dl_q;
	assign load_rise = load_q & ~load_qq;
	assign save_rise = save_q & ~save_qq;
	assign auto_rise = auto_q & ~auto_qq;
	assign ack_rise  = sd_ack & ~ack_q;
	assign ack_fall  = ack_q & ~sd_ack;

	assign last_sector = lba_t'(ram_mask[23:SECTOR_SHIFT]);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q    <= 1'b0;
			dl_qq   <= 1'b0;
			load_q  <= 1'b0;
			load_qq <= 1'b0;
			save_q  <= 1'b0;
			save_qq <= 1'b0;
			auto_q  <= 1'b0;
			auto_qq <= 1'b0;
			ack_q   <= 1'b0;
		end else begin
			dl_q    <= cart_download;
			dl_qq   <= dl_q;
			load_q  <= bk_load_req & bk_ena;
			load_qq <= load_q;
			save_q  <= bk_save_req & bk_ena;
			save_qq <= save_q;
			auto_q  <= bk_pending & osd_open & autosave_en & bk_ena;
			auto_qq <= auto_q;
			ack_q   <= sd_ack;
		end
	end

	// ==============================
	// Enable and dirty flag
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (dl_rise)
				bk_ena <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= |ram_mask;

			if (bk_ena && !osd_open && bsram_wr)
				bk_pending <= 1'b1;
			else if (state != SEQ_IDLE || !bk_ena)
				bk_pending <= 1'b0;
		end
	end

	// ==============================
	// Sector transfer FSM
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= SEQ_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				SEQ_IDLE: begin
					if (dl_fall && bk_ena && img_size != '0) begin
						// Automatic load after a cartridge download
						state      <= SEQ_REQUEST;
						bk_loading <= 1'b1;
						sd_lba     <= '0;
						sd_rd      <= 1'b1;
						sd_wr      <= 1'b0;
					end else if (load_rise || save_rise || auto_rise) begin
						state      <= SEQ_REQUEST;
						bk_loading <= load_rise;
						sd_lba     <= '0;
						sd_rd      <= load_rise;
						sd_wr      <= ~load_rise;
					end
				end
				SEQ_REQUEST: begin
					// Host took the sector
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= SEQ_TRANSFER;
					end
				end
				SEQ_TRANSFER: begin
					if (ack_fall) begin
						if (sd_lba >= last_sector) begin
							bk_loading <= 1'b0;
							state      <= SEQ_IDLE;
						end else begin
							sd_lba <= sd_lba + lba_t'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
							state  <= SEQ_REQUEST;
						end
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/cart_loader.sv
//==============================
// Cartridge loader top
// Download decode, core reset, activity LED
//==============================

`timescale 1ns/10ps
`default_nettype none

module cart_loader import cart_pkg::*; (
	input  wire        clk_sys,
	input  wire        RESET,

	// Host download stream
	input  wire        ioctl_download,
	input  wire  [7:0] ioctl_index,
	input  dl_addr_t   ioctl_addr,
	input  dl_word_t   ioctl_dout,
	input  wire        ioctl_wr,

	// Menu options
	input  hdr_mode_t  header_mode,
	input  wire  [1:0] video_region,
	input  wire  [1:0] wram_init,

	// Save image and SD link
	input  wire        img_mounted,
	input  wire        img_readonly,
	input  lba_t       img_size,
	input  wire        bk_load_req,
	input  wire        bk_save_req,
	input  wire        autosave_en,
	input  wire        osd_open,
	input  wire        bsram_wr,
	input  wire        sd_ack,

	output byte_t      rom_type,
	output mask_t      rom_mask,
	output mask_t      ram_mask,
	output logic       pal,
	output fill_addr_t fill_addr,
	output byte_t      fill_data,
	output logic       fill_wr,
	output lba_t       sd_lba,
	output logic       sd_rd,
	output logic       sd_wr,
	output logic       core_reset,
	output logic       led_activity
);

	logic cart_download;
	logic bk_loading;
	logic bk_pending;

	// Only cartridge images go through this path
	assign cart_download = ioctl_download & (ioctl_index[5:0] == CART_INDEX);

	cart_header_parse i_cart_header_parse (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.header_mode   (header_mode),
		.video_region  (video_region),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	wram_clear i_wram_clear (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.wram_init     (wram_init),
		.fill_addr     (fill_addr),
		.fill_data     (fill_data),
		.fill_wr       (fill_wr)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave_en   (autosave_en),
		.osd_open      (osd_open),
		.bsram_wr      (bsram_wr),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

	// Core held in reset while loading, clearing or restoring the save
	assign core_reset = RESET | cart_download | fill_wr | bk_loading;

	// Lit during downloads and while an autosave is waiting
	assign led_activity = cart_download | (autosave_en & bk_pending);

endmodule

`default_nettype wire

// File: dv/cart_loader_tests.svh
//==============================
// Directed tests for the cartridge loader
//==============================

`ifndef CART_LOADER_TESTS_SVH
`define CART_LOADER_TESTS_SVH

	// Sectors 0 to 3 in order, all one direction
	task automatic expect_sectors(input int base, input logic is_write);
		check("SD transfer count", 32'(lba_log.size() - base), 4);
		for (int i = 0; i < 4; i++) begin
			check("sd_lba", lba_log[base + i], i);
			check("sd_wr", 32'(wr_log[base + i]), 32'(is_write));
		end
	endtask

	// Auto mode, sizes and type from word 0, region from word 2
	task automatic auto_header_case();
		header_mode  = 3'd0;
		video_region = 2'b00;
		dl_addr_q.push_back(25'h0);
		dl_word_q.push_back(16'h2A18);
		dl_addr_q.push_back(25'h2);
		dl_word_q.push_back(16'h0100);
		run_download();
		@(negedge clk_sys);
		check("rom_type", 32'(rom_type), 'h2A);
		check("rom_mask", 32'(rom_mask), 'h3FFFF);
		check("ram_mask", 32'(ram_mask), 'h7FF);
		check("pal", 32'(pal), 1);
		// Menu region overrides the header
		video_region = 2'b01;
		repeat (2) @(negedge clk_sys);
		check("pal", 32'(pal), 0);
		video_region = 2'b10;
		repeat (2) @(negedge clk_sys);
		check("pal", 32'(pal), 1);
		video_region = 2'b00;
	endtask

	task automatic map_case(input logic [2:0] mode, input logic [24:0] rom_at,
			input logic [15:0] rom_word, input logic [15:0] ram_word,
			input logic [31:0] exp_type, input logic [31:0] exp_rom, input logic [31:0] exp_ram);
		header_mode = mode;
		// Word 0 carries values that the mapped modes ignore
		dl_addr_q.push_back(25'h0);
		dl_word_q.push_back(16'h7F35);
		dl_addr_q.push_back(rom_at);
		dl_word_q.push_back(rom_word);
		dl_addr_q.push_back(rom_at + 25'd2);
		dl_word_q.push_back(ram_word);
		run_download();
		check("rom_type", 32'(rom_type), exp_type);
		check("rom_mask", 32'(rom_mask), exp_rom);
		check("ram_mask", 32'(ram_mask), exp_ram);
	endtask

	// Header bases shifted by the 512-byte copier header
	task automatic mapped_header_cases();
		map_case(3'd2, 25'h00081D6, 16'h0A00, 16'h0003, 0, 'hFFFFF, 'h1FFF);
		map_case(3'd3, 25'h00101D6, 16'h0B00, 16'h0005, 1, 'h1FFFFF, 'h7FFF);
		map_case(3'd4, 25'h04101D6, 16'h0D00, 16'h0000, 2, 'h7FFFFF, 0);
	endtask

	task automatic ram_clear_patterns();
		int runs;
		for (int mode = 0; mode < 4; mode++) begin
			wait_fill_idle();
			runs      = fill_runs;
			wram_init = 2'(mode);
			dl_addr_q.push_back(25'h0);
			dl_word_q.push_back(16'h0000);
			run_download();
			wait_fill_idle();
			check("clear runs", 32'(fill_runs - runs), 1);
			check("fill_wr cycles", 32'(fill_count), CLEAR_CYCLES);
		end
	endtask

	// Waits out a load with core reset held while it runs
	task automatic follow_load();
		int n;
		n = 0;
		while (!i_cart_loader.bk_loading) begin
			@(negedge clk_sys);
			n++;
			if (n > 50)
				abort_run("Backup RAM load did not start");
		end
		while (i_cart_loader.bk_loading) begin
			check("core_reset", 32'(core_reset), 1);
			@(negedge clk_sys);
			n++;
			if (n > 2000)
				abort_run("Backup RAM load did not finish");
		end
		check("sd_ack", 32'(sd_ack), 0);
	endtask

	// RAM size code 1 gives 2 KB, four sectors
	task automatic automatic_load();
		int base;
		header_mode  = 3'd0;
		img_mounted  = 1'b1;
		img_readonly = 1'b0;
		img_size     = 32'd2048;
		base         = lba_log.size();
		dl_addr_q.push_back(25'h0);
		dl_word_q.push_back(16'h001C);
		run_download();
		follow_load();
		expect_sectors(base, 1'b0);
		// Explicit load after the clear, reset held by the load alone
		wait_fill_idle();
		check("core_reset", 32'(core_reset), 0);
		base        = lba_log.size();
		bk_load_req = 1'b1;
		@(negedge clk_sys);
		bk_load_req = 1'b0;
		follow_load();
		expect_sectors(base, 1'b0);
	endtask

	task automatic save_and_autosave();
		int base;
		base        = lba_log.size();
		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		wait_sequence_end();
		expect_sectors(base, 1'b1);
		// Save RAM written with the menu closed
		autosave_en = 1'b1;
		bsram_wr    = 1'b1;
		@(negedge clk_sys);
		bsram_wr = 1'b0;
		@(negedge clk_sys);
		check("bk_pending", 32'(i_cart_loader.bk_pending), 1);
		check("led_activity", 32'(led_activity), 1);
		base     = lba_log.size();
		osd_open = 1'b1;
		wait_sequence_end();
		expect_sectors(base, 1'b1);
		check("bk_pending", 32'(i_cart_loader.bk_pending), 0);
		check("led_activity", 32'(led_activity), 0);
		osd_open    = 1'b0;
		autosave_en = 1'b0;
	endtask

	task automatic readonly_image();
		int base;
		base         = lba_log.size();
		img_readonly = 1'b1;
		dl_addr_q.push_back(25'h0);
		dl_word_q.push_back(16'h001C);
		run_download();
		expect_no_requests(40);
		bk_load_req = 1'b1;
		@(negedge clk_sys);
		bk_load_req = 1'b0;
		expect_no_requests(20);
		bk_save_req = 1'b1;
		@(negedge clk_sys);
		bk_save_req = 1'b0;
		expect_no_requests(20);
		autosave_en = 1'b1;
		bsram_wr    = 1'b1;
		@(negedge clk_sys);
		bsram_wr = 1'b0;
		osd_open = 1'b1;
		expect_no_requests(20);
		check("bk_pending", 32'(i_cart_loader.bk_pending), 0);
		check("SD transfer count", 32'(lba_log.size() - base), 0);
		osd_open    = 1'b0;
		autosave_en = 1'b0;
	endtask

`endif

// File: dv/cart_loader_tb.sv
//==============================
// Cartridge loader testbench
// Clock, reset, SD host model, monitors and test sequence
//==============================

`timescale 1ns/10ps
`default_nettype none

module cart_loader_tb;

	localparam int CLEAR_CYCLES    = 131072;
	localparam int DL_COUNT        = 10;
	localparam int WATCHDOG_CYCLES = DL_COUNT * (CLEAR_CYCLES + 3000) + 20000;

	logic        clk_sys = 1'b0;
	logic        RESET;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic [2:0]  header_mode;
	logic [1:0]  video_region;
	logic [1:0]  wram_init;
	logic        img_mounted;
	logic        img_readonly;
	logic [31:0] img_size;
	logic        bk_load_req;
	logic        bk_save_req;
	logic        autosave_en;
	logic        osd_open;
	logic        bsram_wr;
	logic        sd_ack;

	logic [7:0]  rom_type;
	logic [23:0] rom_mask;
	logic [23:0] ram_mask;
	logic        pal;
	logic [16:0] fill_addr;
	logic [7:0]  fill_data;
	logic        fill_wr;
	logic [31:0] sd_lba;
	logic        sd_rd;
	logic        sd_wr;
	logic        core_reset;
	logic        led_activity;

	// SD host log, one entry per acknowledged sector
	logic [15:0] lfsr;
	logic [31:0] lba_log[$];
	logic        wr_log[$];

	// Clear monitor state
	int          fill_count;
	int          fill_runs;
	logic        fill_seen;

	// Words of the next download
	logic [24:0] dl_addr_q[$];
	logic [15:0] dl_word_q[$];

	cart_loader i_cart_loader (.*);

	always #20 clk_sys = ~clk_sys;

	// ==============================
	// Helpers
	// ==============================
	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "%s", reason);
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic lfsr_bit();
		logic bit_out;
		bit_out = lfsr[0];
		lfsr    = lfsr >> 1;
		if (bit_out)
			lfsr = lfsr ^ 16'hB400;
		return bit_out;
	endfunction

	function automatic int ack_delay();
		int d;
		d = 0;
		for (int i = 0; i < 3; i++)
			d = (d << 1) | int'(lfsr_bit());
		return d + 1;
	endfunction

	// Expected power-on pattern per init mode
	function automatic logic [7:0] fill_pattern(input logic [1:0] mode, input logic [16:0] addr);
		case (mode)
			2'd0: return (addr[8] != addr[2]) ? 8'h66 : 8'h99;
			2'd1: return (addr[9] != addr[0]) ? 8'hFF : 8'h00;
			2'd2: return 8'h55;
			default: return 8'hFF;
		endcase
	endfunction

	task automatic wait_fill_idle();
		int n;
		n = 0;
		while (fill_wr) begin
			@(negedge clk_sys);
			n++;
			if (n > CLEAR_CYCLES + 100)
				abort_run("Work RAM clear did not finish");
		end
		@(negedge clk_sys);
	endtask

	// Sends the queued words, one idle cycle between writes
	task automatic run_download();
		wait_fill_idle();
		ioctl_index    = 8'd0;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		while (dl_addr_q.size() > 0) begin
			ioctl_addr = dl_addr_q.pop_front();
			ioctl_dout = dl_word_q.pop_front();
			ioctl_wr   = 1'b1;
			@(negedge clk_sys);
			ioctl_wr = 1'b0;
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		@(negedge clk_sys);
	endtask

	// A sequence has ended once requests stay low for a while
	task automatic wait_sequence_end();
		int n;
		int quiet;
		n     = 0;
		quiet = 0;
		while (!(sd_rd || sd_wr)) begin
			@(negedge clk_sys);
			n++;
			if (n > 100)
				abort_run("No SD request was raised");
		end
		while (quiet < 12) begin
			@(negedge clk_sys);
			quiet = (sd_rd || sd_wr) ? 0 : quiet + 1;
			n++;
			if (n > 2000)
				abort_run("SD transfer sequence did not finish");
		end
	endtask

	task automatic expect_no_requests(input int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			check("sd_rd", 32'(sd_rd), 0);
			check("sd_wr", 32'(sd_wr), 0);
		end
	endtask

	`include "cart_loader_tests.svh"

	// ==============================
	// SD host model
	// ==============================
	initial begin
		int delay;
		logic [31:0] req_lba;
		sd_ack = 1'b0;
		lfsr   = 16'd25;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				check("sd_rd ^ sd_wr", 32'(sd_rd ^ sd_wr), 1);
				req_lba = sd_lba;
				delay   = ack_delay();
				repeat (delay) @(negedge clk_sys);
				check("sd_lba", sd_lba, req_lba);
				lba_log.push_back(sd_lba);
				wr_log.push_back(sd_wr);
				sd_ack = 1'b1;
				repeat (2) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	// Every clear cycle, address order and data
	initial begin
		fill_count = 0;
		fill_runs  = 0;
		fill_seen  = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (fill_wr) begin
				if (!fill_seen)
					fill_count = 0;
				check("fill_addr", 32'(fill_addr), fill_count);
				check("fill_data", 32'(fill_data), 32'(fill_pattern(wram_init, 17'(fill_count))));
				check("core_reset", 32'(core_reset), 1);
				fill_count++;
			end else if (fill_seen) begin
				fill_runs++;
			end
			fill_seen = fill_wr;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		abort_run($sformatf("Watchdog expired after %0d cycles, tests did not finish",
			WATCHDOG_CYCLES));
	end

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = 3'd0;
		video_region   = 2'b00;
		wram_init      = 2'd0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave_en    = 1'b0;
		osd_open       = 1'b0;
		bsram_wr       = 1'b0;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check("fill_wr", 32'(fill_wr), 0);
		check("sd_rd", 32'(sd_rd), 0);
		check("sd_wr", 32'(sd_wr), 0);
		check("pal", 32'(pal), 0);
		check("core_reset", 32'(core_reset), 0);

		auto_header_case();
		mapped_header_cases();
		ram_clear_patterns();
		automatic_load();
		save_and_autosave();
		readonly_image();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+dv
verilog/cart_pkg.sv
verilog/cart_header_parse.sv
verilog/wram_clear.sv
verilog/backup_sequencer.sv
verilog/cart_loader.sv
dv/cart_loader_tb.sv

// File: Makefile
SIM        = verilator
TOP        = cart_loader_tb
RTL_TOP    = cart_loader
FILELIST   = filelist.f
FLAGS      = --binary --timing
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
